/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_exec_core
FILELIST  ?= files.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* alu_unit.sv */
module alu_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            issue_valid,
    input  rob_pkg::issue_t issue,
    output logic            done_valid,
    output rob_pkg::done_t  done
);

    logic [rob_pkg::XLEN-1:0] result;           // Combinational ALU output

    always_comb begin
        case (issue.op)
            rob_pkg::ADD: result = issue.a + issue.b;
            rob_pkg::SUB: result = issue.a - issue.b;
            rob_pkg::AND: result = issue.a & issue.b;
            rob_pkg::OR:  result = issue.a | issue.b;
            rob_pkg::XOR: result = issue.a ^ issue.b;
            rob_pkg::BRZ: result = issue.pc + issue.b;  // Branch target
            default:      result = '0;          // MUL and DIV never come here
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_valid <= 1'b0;
        end else if (flush) begin
            done_valid <= 1'b0;                 // Kill result of a flushed op
        end else begin
            done_valid <= issue_valid;          // One cycle latency
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            done.tag   <= issue.tag;
            done.value <= result;
            done.taken <= (issue.op == rob_pkg::BRZ) && (issue.a == '0);
        end
    end

endmodule

/* div_unit.sv */
module div_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            issue_valid,
    input  rob_pkg::issue_t issue,
    output logic            done_valid,
    output rob_pkg::done_t  done,
    output logic            busy
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,                                    // One quotient bit per cycle
        DONE                                    // Result strobe cycle
    } state_e;

    state_e                                 state;
    logic [$clog2(rob_pkg::DIV_CYCLES)-1:0] cnt;        // Iteration counter
    rob_pkg::tag_t                          tag_q;
    logic [rob_pkg::XLEN-1:0]               divisor_q;
    logic [rob_pkg::XLEN-1:0]               quo_q;      // Dividend shifts out, quotient in
    logic [rob_pkg::XLEN-1:0]               rem_q;      // Partial remainder, below divisor
    logic                                   div_zero_q;
    logic [rob_pkg::XLEN:0]                 rem_shift;
    logic [rob_pkg::XLEN:0]                 diff;

    assign rem_shift = {rem_q, quo_q[rob_pkg::XLEN-1]};
    assign diff      = rem_shift - {1'b0, divisor_q};  // MSB set means negative

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else if (flush) begin
            state <= IDLE;                      // Abandon the division
        end else begin
            case (state)
                IDLE, DONE: begin
                    state <= issue_valid ? RUN : IDLE;
                    cnt   <= '0;
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == $bits(cnt)'(rob_pkg::DIV_CYCLES - 1)) begin
                        state <= DONE;          // Last bit this cycle
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            tag_q      <= issue.tag;
            divisor_q  <= issue.b;
            quo_q      <= issue.a;
            rem_q      <= '0;
            div_zero_q <= (issue.b == '0);
        end else if (state == RUN) begin
            if (!diff[rob_pkg::XLEN]) begin
                rem_q <= diff[rob_pkg::XLEN-1:0];       // Subtract fits, bit is one
                quo_q <= {quo_q[rob_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[rob_pkg::XLEN-1:0];  // Restore
                quo_q <= {quo_q[rob_pkg::XLEN-2:0], 1'b0};
            end
        end
    end

    assign busy       = (state == RUN);
    assign done_valid = (state == DONE);
    assign done.tag   = tag_q;
    assign done.value = div_zero_q ? '1 : quo_q;  // All ones on divide by zero
    assign done.taken = 1'b0;

    // Issue stage holds DIVs back while busy
    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !busy);

endmodule

/* exec_core_top.sv */
module exec_core_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  rob_pkg::inst_t     inst,
    output logic               inst_ready,
    output logic               commit_valid,
    output rob_pkg::commit_t   commit,
    output logic               redirect_valid,
    output rob_pkg::redirect_t redirect
);

    logic            alloc_valid;               // Issue to ROB
    rob_pkg::alloc_t alloc;
    rob_pkg::tag_t   alloc_tag;                 // ROB tail back to issue
    logic            full;
    logic            flush;                     // From ROB to all stages
    logic            div_busy;
    logic            alu_issue_valid;
    logic            mul_issue_valid;
    logic            div_issue_valid;
    rob_pkg::issue_t issue;                     // Shared by all three units
    logic            alu_done_valid;
    logic            mul_done_valid;
    logic            div_done_valid;
    rob_pkg::done_t  alu_done;
    rob_pkg::done_t  mul_done;
    rob_pkg::done_t  div_done;

    issue_stage u_issue (.*);                   // Names match one to one

    alu_unit u_alu (
        .*,
        .issue_valid (alu_issue_valid),
        .done_valid  (alu_done_valid),
        .done        (alu_done)
    );

    mul_unit u_mul (
        .*,
        .issue_valid (mul_issue_valid),
        .done_valid  (mul_done_valid),
        .done        (mul_done)
    );

    div_unit u_div (
        .*,
        .issue_valid (div_issue_valid),
        .done_valid  (div_done_valid),
        .done        (div_done),
        .busy        (div_busy)
    );

    reorder_buffer u_rob (.*);

endmodule

/* files.f */
rob_pkg.sv
issue_stage.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
reorder_buffer.sv
exec_core_top.sv
tb_checker.sv
tb_exec_core.sv

/* issue_stage.sv */
module issue_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  rob_pkg::inst_t  inst,
    input  logic            full,
    input  logic            div_busy,
    input  logic            flush,
    input  rob_pkg::tag_t   alloc_tag,
    output logic            inst_ready,
    output logic            alloc_valid,
    output rob_pkg::alloc_t alloc,
    output logic            alu_issue_valid,
    output logic            mul_issue_valid,
    output logic            div_issue_valid,
    output rob_pkg::issue_t issue
);

    logic           hold_valid;                 // Issue register occupied
    rob_pkg::inst_t hold;                       // Issue register payload
    logic           dispatch;                   // Held op leaves this cycle
    logic           is_mul;
    logic           is_div;
    logic           is_brz;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= inst_valid && !flush; // Held for exactly one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            hold <= inst;
        end
    end

    // Opcode decode
    assign is_mul = (hold.op == rob_pkg::MUL);
    assign is_div = (hold.op == rob_pkg::DIV);
    assign is_brz = (hold.op == rob_pkg::BRZ);

    assign dispatch   = hold_valid && !flush;   // Flush drops the held op
    assign inst_ready = !full && !div_busy && !hold_valid && !flush;

    assign alloc_valid     = dispatch;
    assign alloc.rd        = hold.rd;
    assign alloc.reg_write = !is_brz;           // Branches write nothing
    assign alloc.is_branch = is_brz;

    assign alu_issue_valid = dispatch && !is_mul && !is_div;  // BRZ resolves here too
    assign mul_issue_valid = dispatch && is_mul;
    assign div_issue_valid = dispatch && is_div;

    assign issue.tag = alloc_tag;               // Tail slot from the ROB
    assign issue.op  = hold.op;
    assign issue.a   = hold.a;
    assign issue.b   = hold.b;
    assign issue.pc  = hold.pc;

    // Source must honour full, divider busy and flush
    a_inst_when_ready: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_ready);

endmodule

/* mul_unit.sv */
module mul_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            issue_valid,
    input  rob_pkg::issue_t issue,
    output logic            done_valid,
    output rob_pkg::done_t  done
);

    logic [rob_pkg::MUL_STAGES-1:0] stage_valid;            // One valid per stage
    rob_pkg::tag_t                  stage_tag [rob_pkg::MUL_STAGES];
    logic [rob_pkg::XLEN-1:0]       stage_pp  [rob_pkg::MUL_STAGES];  // Partial product
    logic [rob_pkg::XLEN-1:0]       a_q;                    // Multiplicand for upper half
    logic [rob_pkg::XLEN-1:0]       b_lo;                   // Zero-extended low half of b
    logic [rob_pkg::XLEN-1:0]       b_hi_q;                 // Zero-extended high half of b

    assign b_lo = {{(rob_pkg::XLEN/2){1'b0}}, issue.b[rob_pkg::XLEN/2-1:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (flush) begin
            stage_valid <= '0;                  // Empty the whole pipe
        end else begin
            stage_valid <= {stage_valid[rob_pkg::MUL_STAGES-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        // Stage 0 multiplies by the low half of b
        stage_tag[0] <= issue.tag;
        stage_pp[0]  <= issue.a * b_lo;
        a_q          <= issue.a;
        b_hi_q       <= {{(rob_pkg::XLEN/2){1'b0}}, issue.b[rob_pkg::XLEN-1:rob_pkg::XLEN/2]};
        // Stage 1 adds the shifted upper half, low XLEN bits kept
        stage_tag[1] <= stage_tag[0];
        stage_pp[1]  <= stage_pp[0] + ((a_q * b_hi_q) << (rob_pkg::XLEN/2));
        for (int i = 2; i < rob_pkg::MUL_STAGES; i++) begin
            stage_tag[i] <= stage_tag[i-1];     // Pure delay stages
            stage_pp[i]  <= stage_pp[i-1];
        end
    end

    assign done_valid = stage_valid[rob_pkg::MUL_STAGES-1];
    assign done.tag   = stage_tag[rob_pkg::MUL_STAGES-1];
    assign done.value = stage_pp[rob_pkg::MUL_STAGES-1];
    assign done.taken = 1'b0;

endmodule

/* reorder_buffer.sv */
module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_valid,
    input  rob_pkg::alloc_t    alloc,
    output rob_pkg::tag_t      alloc_tag,
    output logic               full,
    input  logic               alu_done_valid,
    input  logic               mul_done_valid,
    input  logic               div_done_valid,
    input  rob_pkg::done_t     alu_done,
    input  rob_pkg::done_t     mul_done,
    input  rob_pkg::done_t     div_done,
    output logic               commit_valid,
    output rob_pkg::commit_t   commit,
    output logic               redirect_valid,
    output rob_pkg::redirect_t redirect,
    output logic               flush
);

    typedef struct packed {
        logic [4:0]               rd;
        logic                     reg_write;
        logic                     is_branch;
        logic                     taken;
        logic [rob_pkg::XLEN-1:0] value;        // Result or branch target
    } entry_t;

    logic [rob_pkg::ROB_DEPTH-1:0] ent_valid;   // Slot allocated
    logic [rob_pkg::ROB_DEPTH-1:0] ent_ready;   // Result written back
    entry_t                        entries [rob_pkg::ROB_DEPTH];
    rob_pkg::tag_t                 head;        // Oldest entry
    rob_pkg::tag_t                 tail;        // Next free slot
    logic [rob_pkg::TAG_W:0]       count;       // Occupied entries, 0 to ROB_DEPTH
    logic                          commit_fire; // Head retires on next edge
    logic                          do_alloc;
    entry_t                        head_entry;
    logic [2:0]                    done_v;      // Result ports as arrays
    rob_pkg::done_t                done_p [3];

    assign done_v    = {div_done_valid, mul_done_valid, alu_done_valid};
    assign done_p[0] = alu_done;
    assign done_p[1] = mul_done;
    assign done_p[2] = div_done;

    assign head_entry  = entries[head];
    assign commit_fire = ent_valid[head] && ent_ready[head];
    assign flush       = commit_fire && head_entry.is_branch && head_entry.taken;
    assign do_alloc    = alloc_valid && !flush; // Flush wins over allocation
    assign alloc_tag   = tail;
    assign full        = (count == $bits(count)'(rob_pkg::ROB_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid      <= '0;
            ent_ready      <= '0;
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid   <= commit_fire;      // Registered commit strobe
            redirect_valid <= flush;
            for (int p = 0; p < 3; p++) begin
                if (done_v[p]) begin
                    ent_ready[done_p[p].tag] <= 1'b1;  // Ports never share a tag
                end
            end
            if (do_alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (commit_fire) begin
                ent_valid[head] <= 1'b0;
                ent_ready[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (flush) begin
                ent_valid <= '0;                // Branch retires, younger ones die
                ent_ready <= '0;
                tail      <= head + 1'b1;
                count     <= '0;
            end else if (do_alloc && !commit_fire) begin
                count <= count + 1'b1;
            end else if (!do_alloc && commit_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            entries[tail].rd        <= alloc.rd;
            entries[tail].reg_write <= alloc.reg_write;
            entries[tail].is_branch <= alloc.is_branch;
            entries[tail].taken     <= 1'b0;
        end
        for (int p = 0; p < 3; p++) begin
            if (done_v[p]) begin
                entries[done_p[p].tag].value <= done_p[p].value;
                entries[done_p[p].tag].taken <= done_p[p].taken;
            end
        end
        if (commit_fire) begin
            commit.rd        <= head_entry.rd;
            commit.value     <= head_entry.value;
            commit.reg_write <= head_entry.reg_write;
        end
        if (flush) begin
            redirect <= head_entry.value;       // Target computed by the ALU
        end
    end

    // Issue stage must see full before allocating
    a_alloc_not_full: assert property (@(posedge clk) disable iff (rst)
        alloc_valid |-> !full);

    // Units only report tags that are still live in the buffer
    a_done_live_entry: assert property (@(posedge clk) disable iff (rst)
        (!done_v[0] || ent_valid[done_p[0].tag]) &&
        (!done_v[1] || ent_valid[done_p[1].tag]) &&
        (!done_v[2] || ent_valid[done_p[2].tag]));

endmodule

/* rob_pkg.sv */
package rob_pkg;

    localparam int ROB_DEPTH  = 16;             // Reorder buffer entries
    localparam int TAG_W      = 4;              // Bits to index ROB_DEPTH
    localparam int XLEN       = 32;             // Datapath width
    localparam int MUL_STAGES = 3;              // Multiplier latency in cycles
    localparam int DIV_CYCLES = 32;             // One quotient bit per cycle

    typedef logic [TAG_W-1:0] tag_t;            // ROB entry index

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        MUL = 3'd5,
        DIV = 3'd6,
        BRZ = 3'd7                              // Taken when a is zero
    } op_e;

    typedef struct packed {
        op_e             op;
        logic [4:0]      rd;                    // Destination register
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
    } inst_t;

    typedef struct packed {
        tag_t            tag;                   // ROB slot of this op
        op_e             op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] pc;
    } issue_t;

    typedef struct packed {
        logic [4:0] rd;
        logic       reg_write;                  // Low only for BRZ
        logic       is_branch;
    } alloc_t;

    typedef struct packed {
        tag_t            tag;
        logic [XLEN-1:0] value;                 // Branch target for BRZ
        logic            taken;
    } done_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        logic            reg_write;
    } commit_t;

    typedef logic [XLEN-1:0] redirect_t;        // Fetch restart address

endpackage

/* tb_checker.sv */
module tb_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  rob_pkg::inst_t     inst,
    input  logic               commit_valid,
    input  rob_pkg::commit_t   commit,
    input  logic               redirect_valid,
    input  rob_pkg::redirect_t redirect,
    output int                 mismatches,
    output int                 failures,
    output int                 pending
);

    typedef struct packed {
        rob_pkg::commit_t         c;            // Retirement the DUT must show
        logic                     taken;        // Taken BRZ, redirect expected
        logic [rob_pkg::XLEN-1:0] target;
    } expect_t;

    expect_t exp_q [$];                         // Oldest instruction at the front

    // Expected retirement of one instruction
    function automatic expect_t predict(input rob_pkg::inst_t i);
        expect_t e;
        e.c.rd        = i.rd;
        e.c.reg_write = (i.op != rob_pkg::BRZ);  // Branches write no register
        e.taken       = (i.op == rob_pkg::BRZ) && (i.a == '0);
        e.target      = i.pc + i.b;
        case (i.op)
            rob_pkg::ADD: e.c.value = i.a + i.b;
            rob_pkg::SUB: e.c.value = i.a - i.b;
            rob_pkg::AND: e.c.value = i.a & i.b;
            rob_pkg::OR:  e.c.value = i.a | i.b;
            rob_pkg::XOR: e.c.value = i.a ^ i.b;
            rob_pkg::MUL: e.c.value = i.a * i.b;         // Low word only
            rob_pkg::DIV: e.c.value = (i.b == '0) ? '1 : i.a / i.b;
            default:      e.c.value = i.pc + i.b;        // BRZ retires its target
        endcase
        return e;
    endfunction

    task automatic compare(input string name, input logic [31:0] want,
                           input logic [31:0] got);
        if (got !== want) begin
            mismatches++;
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, want, got);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    always @(posedge clk) begin
        expect_t e;
        logic    took;
        took = 1'b0;
        if (!rst) begin
            if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("commit strobe with no instruction left to retire");
                end else begin
                    e    = exp_q.pop_front();
                    took = e.taken;
                    compare("commit.rd", 32'(e.c.rd), 32'(commit.rd));
                    compare("commit.value", e.c.value, commit.value);
                    compare("commit.reg_write", 32'(e.c.reg_write), 32'(commit.reg_write));
                    if (took) begin
                        if (redirect_valid) begin
                            compare("redirect", e.target, redirect);
                        end else begin
                            report_failure("taken BRZ retired without a redirect");
                        end
                        exp_q.delete();         // Younger work is squashed
                    end
                end
            end
            if (redirect_valid && !took) begin
                report_failure("redirect strobe with no taken BRZ retiring");
            end
            if (inst_valid) begin
                exp_q.push_back(predict(inst)); // After the squash, so it survives
            end
        end
        pending = exp_q.size();
    end

endmodule

/* tb_exec_core.sv */
module tb_exec_core;

    localparam int          CLK_PERIOD    = 40;
    localparam int          RESET_CYCLES  = 16;
    localparam int          READY_TIMEOUT = 200;        // Longer than one divide
    localparam int          DRAIN_TIMEOUT = 2000;
    localparam logic [31:0] LFSR_SEED     = 32'hd234_42f2;
    localparam int          ROWS          = 21;

    typedef struct packed {
        rob_pkg::op_e op;
        logic [4:0]   rd;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  pc;
        logic         rand_a;                   // Take a from the LFSR
        logic         rand_b;
        logic [3:0]   gap;                      // Idle cycles after the strobe
        logic [4:0]   reps;                     // Copies sent back to back
    } row_t;

    // op, rd, a, b, pc, rand_a, rand_b, gap, reps
    row_t stim [ROWS] = '{
        '{rob_pkg::ADD, 5'd1,  32'd0, 32'd0, 32'h100, 1'b1, 1'b1, 4'd1, 5'd1},
        '{rob_pkg::SUB, 5'd2,  32'd0, 32'd0, 32'h104, 1'b1, 1'b1, 4'd0, 5'd1},
        '{rob_pkg::AND, 5'd3,  32'd0, 32'd0, 32'h108, 1'b1, 1'b1, 4'd2, 5'd1},
        '{rob_pkg::OR,  5'd4,  32'd0, 32'd0, 32'h10c, 1'b1, 1'b1, 4'd0, 5'd1},
        '{rob_pkg::XOR, 5'd5,  32'd0, 32'd0, 32'h110, 1'b1, 1'b1, 4'd0, 5'd1},
        '{rob_pkg::SUB, 5'd6,  32'd5, 32'd7, 32'h114, 1'b0, 1'b0, 4'd0, 5'd1},  // Wraps
        '{rob_pkg::MUL, 5'd7,  32'd0, 32'd0, 32'h118, 1'b1, 1'b1, 4'd0, 5'd3},
        '{rob_pkg::MUL, 5'd8,  32'hffff_ffff, 32'd3, 32'h124, 1'b0, 1'b0, 4'd0, 5'd1},
        '{rob_pkg::DIV, 5'd9,  32'd100, 32'd7, 32'h128, 1'b0, 1'b0, 4'd0, 5'd1},
        '{rob_pkg::DIV, 5'd10, 32'd1234, 32'd0, 32'h12c, 1'b0, 1'b0, 4'd0, 5'd1}, // By zero
        '{rob_pkg::DIV, 5'd11, 32'd0, 32'd0, 32'h130, 1'b1, 1'b1, 4'd0, 5'd1},
        '{rob_pkg::ADD, 5'd12, 32'd0, 32'd0, 32'h134, 1'b1, 1'b1, 4'd0, 5'd2},
        '{rob_pkg::MUL, 5'd13, 32'd0, 32'd0, 32'h13c, 1'b1, 1'b1, 4'd0, 5'd1},
        '{rob_pkg::SUB, 5'd14, 32'd0, 32'd0, 32'h140, 1'b1, 1'b1, 4'd3, 5'd1},
        '{rob_pkg::BRZ, 5'd0,  32'd1, 32'h40, 32'h200, 1'b0, 1'b0, 4'd0, 5'd1},  // Not taken
        '{rob_pkg::MUL, 5'd15, 32'd0, 32'd0, 32'h204, 1'b1, 1'b1, 4'd0, 5'd1},
        '{rob_pkg::BRZ, 5'd0,  32'd0, 32'h80, 32'h208, 1'b0, 1'b0, 4'd0, 5'd1},  // Taken
        '{rob_pkg::ADD, 5'd16, 32'd0, 32'd0, 32'h20c, 1'b1, 1'b1, 4'd0, 5'd3},   // Shadow
        '{rob_pkg::XOR, 5'd17, 32'd0, 32'd0, 32'h288, 1'b1, 1'b1, 4'd2, 5'd1},
        '{rob_pkg::DIV, 5'd18, 32'd0, 32'd0, 32'h28c, 1'b1, 1'b1, 4'd0, 5'd16},  // Burst
        '{rob_pkg::ADD, 5'd19, 32'd0, 32'd0, 32'h2cc, 1'b1, 1'b1, 4'd0, 5'd1}
    };

    logic               clk;
    logic               rst;
    logic               inst_valid;
    rob_pkg::inst_t     inst;
    logic               inst_ready;
    logic               commit_valid;
    rob_pkg::commit_t   commit;
    logic               redirect_valid;
    rob_pkg::redirect_t redirect;
    int                 mismatches;             // From the checker
    int                 failures;
    int                 pending;                // Expected commits still owed
    int                 timeouts;
    int                 tb_errors;
    logic [31:0]        lfsr;

    always #(CLK_PERIOD / 2) clk = ~clk;

    exec_core_top DUT (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_ready     (inst_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    tb_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .mismatches     (mismatches),
        .failures       (failures),
        .pending        (pending)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[31]};         // One step per bit taken
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Waits for inst_ready, then strobes one copy of a table row
    task automatic send_row(input row_t row, input int r, output bit ok);
        int cycles;
        cycles = 0;
        while (!inst_ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = inst_ready;
        if (!ok) begin
            timeouts++;
            $display("ERROR t=%0t inst_ready stayed low for %0d cycles", $time, cycles);
        end else begin
            inst_valid = 1'b1;
            inst.op    = row.op;
            inst.rd    = row.rd;
            inst.a     = row.rand_a ? draw_bits(32) : row.a;
            // Short divisors keep random quotients away from zero
            inst.b     = row.rand_b ? draw_bits(row.op == rob_pkg::DIV ? 12 : 32) : row.b;
            inst.pc    = row.pc + 32'(4 * r);
            @(negedge clk);
            inst_valid = 1'b0;
            repeat (row.gap) @(negedge clk);
        end
    endtask

    initial begin
        bit ok;
        int cycles;
        ok         = 1'b1;
        cycles     = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        lfsr       = LFSR_SEED;
        timeouts   = 0;
        tb_errors  = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (!inst_ready) begin
            tb_errors++;
            $display("ERROR t=%0t inst_ready is low after reset", $time);
        end
        repeat (4) @(negedge clk);              // Idle window, no strobe may appear
        for (int i = 0; i < ROWS && ok; i++) begin
            for (int r = 0; r < int'(stim[i].reps) && ok; r++) begin
                send_row(stim[i], r, ok);
            end
        end
        while (ok && pending != 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ok && pending != 0) begin
            timeouts++;
            $display("ERROR t=%0t %0d instructions never retired", $time, pending);
        end
        repeat (8) @(negedge clk);              // Room for a stray late commit
        $display("Error counts: %0d mismatches, %0d checker failures, %0d timeouts, %0d other",
                 mismatches, failures, timeouts, tb_errors);
        if (mismatches + failures + timeouts + tb_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
